//--- hw/mCyclePkg.sv
package mCyclePkg;

    // operand width of the unit.
    localparam int Width = 32;

    // one add-and-shift step per multiplier bit.
    localparam int MulSteps = Width;

    // the divisor starts in the upper half, so one more compare is needed
    // before its lowest bit lines up with the dividend's top bit.
    localparam int DivSteps = Width + 1;

    typedef logic [Width-1:0]   operandT;
    typedef logic [2*Width-1:0] productT;

    // wide enough to count up to DivSteps.
    typedef logic [5:0] countT;

    typedef enum logic {
        OpMultiply = 1'b0,
        OpDivide   = 1'b1
    } mCycleOpT;

    typedef enum logic {
        Idle,
        Computing
    } cycleStateT;

endpackage

//--- hw/MCycleControl.sv
`timescale 1ns/1ps

module MCycleControl import mCyclePkg::*; (
    input  logic     CLK,
    input  logic     Reset,
    input  logic     Start,
    input  mCycleOpT MCycleOp,
    output logic     Init,
    output logic     Shift,
    output logic     Busy,
    output logic     StepsDone
);

    cycleStateT currentState;
    cycleStateT nextState;
    countT      count;
    mCycleOpT   opHeld;
    countT      lastStep;

    // Start is only looked at while idle, so a new request during a
    // computation is dropped.
    always_comb begin
        case (currentState)
            Idle: begin
                nextState = Start ? Computing : Idle;
                Busy      = Start;
            end
            Computing: begin
                nextState = StepsDone ? Idle : Computing;
                Busy      = 1'b1;
            end
            default: begin
                nextState = Idle;
                Busy      = 1'b0;
            end
        endcase
    end

    assign Init = (currentState == Idle) && (nextState == Computing);

    // the step count comes from the operation latched at Init.
    assign lastStep = (opHeld == OpDivide) ? countT'(DivSteps - 1) : countT'(MulSteps - 1);

    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            currentState <= Idle;
        end else begin
            currentState <= nextState;
        end
    end

    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            count     <= '0;
            Shift     <= 1'b0;
            StepsDone <= 1'b0;
            opHeld    <= OpMultiply;
        end else begin
            StepsDone <= 1'b0;
            if (Init) begin
                count  <= '0;
                Shift  <= 1'b1;
                opHeld <= MCycleOp;
            end else if (Shift) begin
                if (count == lastStep) begin
                    // final step taken on this edge.
                    count     <= '0;
                    Shift     <= 1'b0;
                    StepsDone <= 1'b1;
                end else begin
                    count <= count + 1'b1;
                end
            end
        end
    end

endmodule

//--- hw/ShiftAddMultiplier.sv
`timescale 1ns/1ps

module ShiftAddMultiplier import mCyclePkg::*; (
    input  logic    CLK,
    input  logic    Reset,
    input  logic    Init,
    input  logic    Shift,
    input  operandT Operand1,
    input  operandT Operand2,
    output productT Product
);

    operandT          multiplicand;
    // upper half of the running product.
    operandT          accumulator;
    // the multiplier drains out of the bottom while product bits enter the top.
    operandT          multiplier;
    logic [Width:0]   partialSum;
    operandT          addend;

    assign addend     = multiplier[0] ? multiplicand : '0;
    assign partialSum = {1'b0, accumulator} + {1'b0, addend};

    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            multiplicand <= '0;
            accumulator  <= '0;
            multiplier   <= '0;
        end else if (Init) begin
            multiplicand <= Operand1;
            accumulator  <= '0;
            multiplier   <= Operand2;
        end else if (Shift) begin
            // the carry out of the add becomes the new top bit.
            accumulator <= partialSum[Width:1];
            multiplier  <= {partialSum[0], multiplier[Width-1:1]};
        end
    end

    // after MulSteps steps the two halves hold the full product.
    assign Product = {accumulator, multiplier};

endmodule

//--- hw/RestoringDivider.sv
`timescale 1ns/1ps

module RestoringDivider import mCyclePkg::*; (
    input  logic    CLK,
    input  logic    Reset,
    input  logic    Init,
    input  logic    Shift,
    input  operandT Operand1,
    input  operandT Operand2,
    output operandT Quotient,
    output operandT Remainder
);

    productT workRemainder;
    productT workDivisor;
    operandT quotientReg;
    productT difference;
    logic    fits;

    // the subtraction is only kept when the divisor fits.
    assign difference = workRemainder - workDivisor;
    assign fits       = (workRemainder >= workDivisor);

    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            workRemainder <= '0;
            workDivisor   <= '0;
            quotientReg   <= '0;
        end else if (Init) begin
            workRemainder <= {{Width{1'b0}}, Operand1};
            workDivisor   <= {Operand2, {Width{1'b0}}};
            quotientReg   <= '0;
        end else if (Shift) begin
            if (fits) begin
                workRemainder <= difference;
                quotientReg   <= {quotientReg[Width-2:0], 1'b1};
            end else begin
                quotientReg <= {quotientReg[Width-2:0], 1'b0};
            end
            workDivisor <= workDivisor >> 1;
        end
    end

    // the first compare can only succeed for a zero divisor, and its bit is
    // shifted out again. With a zero divisor every step fits, which leaves
    // an all-ones quotient and the dividend as remainder.
    assign Quotient  = quotientReg;
    assign Remainder = workRemainder[Width-1:0];

endmodule

//--- hw/ResultSelect.sv
`timescale 1ns/1ps

module ResultSelect import mCyclePkg::*; (
    input  logic     CLK,
    input  logic     Reset,
    input  logic     Init,
    input  mCycleOpT MCycleOp,
    input  logic     StepsDone,
    input  productT  Product,
    input  operandT  Quotient,
    input  operandT  Remainder,
    output operandT  Result1,
    output operandT  Result2,
    output logic     Done
);

    mCycleOpT opHeld;

    // the operation is frozen at Init so the selection is not disturbed
    // by the caller changing MCycleOp mid-computation.
    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            opHeld <= OpMultiply;
        end else if (Init) begin
            opHeld <= MCycleOp;
        end
    end

    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            Result1 <= '0;
            Result2 <= '0;
            Done    <= 1'b0;
        end else begin
            Done <= StepsDone;
            if (StepsDone) begin
                if (opHeld == OpDivide) begin
                    Result1 <= Quotient;
                    Result2 <= Remainder;
                end else begin
                    Result1 <= Product[Width-1:0];
                    Result2 <= Product[2*Width-1:Width];
                end
            end
        end
    end

endmodule

//--- hw/MCycleUnit.sv
`timescale 1ns/1ps

module MCycleUnit import mCyclePkg::*; (
    input  logic     CLK,
    input  logic     Reset,
    input  logic     Start,
    input  mCycleOpT MCycleOp,
    input  operandT  Operand1,
    input  operandT  Operand2,
    output operandT  Result1,
    output operandT  Result2,
    output logic     Busy,
    output logic     Done
);

    logic    init;
    logic    shift;
    logic    stepsDone;
    productT product;
    operandT quotient;
    operandT remainder;

    MCycleControl control (
        .CLK       (CLK),
        .Reset     (Reset),
        .Start     (Start),
        .MCycleOp  (MCycleOp),
        .Init      (init),
        .Shift     (shift),
        .Busy      (Busy),
        .StepsDone (stepsDone)
    );

    // both datapaths run on every operation; the result stage picks one.
    ShiftAddMultiplier multiplier (
        .CLK      (CLK),
        .Reset    (Reset),
        .Init     (init),
        .Shift    (shift),
        .Operand1 (Operand1),
        .Operand2 (Operand2),
        .Product  (product)
    );

    RestoringDivider divider (
        .CLK       (CLK),
        .Reset     (Reset),
        .Init      (init),
        .Shift     (shift),
        .Operand1  (Operand1),
        .Operand2  (Operand2),
        .Quotient  (quotient),
        .Remainder (remainder)
    );

    ResultSelect resultSelect (
        .CLK       (CLK),
        .Reset     (Reset),
        .Init      (init),
        .MCycleOp  (MCycleOp),
        .StepsDone (stepsDone),
        .Product   (product),
        .Quotient  (quotient),
        .Remainder (remainder),
        .Result1   (Result1),
        .Result2   (Result2),
        .Done      (Done)
    );

endmodule

//--- bench/MCycleChecker.sv
`timescale 1ns/1ps

module MCycleChecker import mCyclePkg::*; (
    input  logic     CLK,
    input  logic     Reset,
    input  logic     Start,
    input  mCycleOpT MCycleOp,
    input  operandT  Operand1,
    input  operandT  Operand2,
    input  operandT  Result1,
    input  operandT  Result2,
    input  logic     Busy,
    input  logic     Done,
    input  logic     Finished,
    input  int       CycleLimit,
    output int       PassCount,
    output int       FailCount,
    output logic     TimedOut
);

    logic     pending;
    logic     anyAccepted;
    logic     closed;
    mCycleOpT opHeld;
    operandT  aHeld;
    operandT  bHeld;
    int       edgeCount;
    int       testIndex;
    int       cycleCount = 0;
    int       resetChecks;
    int       resetErrors;
    int       busyErrors;

    // expected {Result2, Result1} for one operation.
    function automatic productT referenceResult(mCycleOpT op, operandT a, operandT b);
        if (op == OpMultiply) begin
            return productT'(a) * productT'(b);
        end
        // a zero divisor gives an all-ones quotient and keeps the dividend.
        if (b == '0) begin
            return {a, {Width{1'b1}}};
        end
        return {a % b, a / b};
    endfunction

    // Done rises N+1 edges after the edge that took Start.
    function automatic int expectedEdges(mCycleOpT op);
        return (op == OpDivide) ? DivSteps + 1 : MulSteps + 1;
    endfunction

    task automatic tallyTest(string name, logic ok);
        if (ok) begin
            PassCount++;
            $display("test %s passed", name);
        end else begin
            FailCount++;
            $display("test %s failed", name);
        end
    endtask

    task automatic finishOp();
        string   name;
        productT expected;
        productT actual;
        logic    ok;
        name     = $sformatf("op%0d_%s", testIndex, (opHeld == OpDivide) ? "div" : "mul");
        expected = referenceResult(opHeld, aHeld, bHeld);
        actual   = {Result2, Result1};
        ok       = 1'b1;
        if (actual !== expected) begin
            $display("ERROR %s expected 0x%016h actual 0x%016h", name, expected, actual);
            ok = 1'b0;
        end
        // Done is seen here one edge after it was raised.
        if (edgeCount - 1 != expectedEdges(opHeld)) begin
            $display("%s: Done came %0d edges after Start instead of %0d",
                name, edgeCount - 1, expectedEdges(opHeld));
            ok = 1'b0;
        end
        if (busyErrors != 0) begin
            $display("%s: Busy was wrong in %0d cycles of the operation", name, busyErrors);
            ok = 1'b0;
        end
        tallyTest(name, ok);
        pending = 1'b0;
    endtask

    always @(posedge CLK) begin
        cycleCount++;
        if (Reset) begin
            PassCount   = 0;
            FailCount   = 0;
            TimedOut    = 1'b0;
            pending     = 1'b0;
            anyAccepted = 1'b0;
            closed      = 1'b0;
            testIndex   = 0;
            resetChecks = 0;
            resetErrors = 0;
            busyErrors  = 0;
        end else begin
            if (cycleCount >= CycleLimit && !TimedOut) begin
                $display("timeout: the run did not end within %0d cycles", CycleLimit);
                TimedOut = 1'b1;
            end
            if (!anyAccepted && !Start) begin
                resetChecks++;
                if ({Busy, Done, Result2, Result1} !== '0) begin
                    resetErrors++;
                    $display("ERROR resetState expected 0x0 actual 0x%0h",
                        {Busy, Done, Result2, Result1});
                end
            end
            if (pending) begin
                edgeCount++;
            end
            // Busy stays high from the Start edge until Done, and in the Done
            // cycle it is only high again for a new Start.
            if (pending && (Done ? (Busy !== Start) : (Busy !== 1'b1))) begin
                busyErrors++;
            end
            if (Done && pending) begin
                finishOp();
            end else if (Done) begin
                FailCount++;
                $display("Done was raised with no operation in progress");
            end else if (pending && edgeCount > expectedEdges(opHeld) + 3) begin
                FailCount++;
                $display("op%0d: no Done within %0d edges of Start", testIndex, edgeCount);
                pending = 1'b0;
            end
            // the unit is idle again in the Done cycle, so a Start there is taken.
            if (Start && !pending) begin
                if (!anyAccepted) begin
                    if (resetChecks == 0) begin
                        $display("no idle cycle was seen between reset and the first Start");
                    end
                    tallyTest("resetState", resetChecks > 0 && resetErrors == 0);
                end
                anyAccepted = 1'b1;
                pending     = 1'b1;
                opHeld      = MCycleOp;
                aHeld       = Operand1;
                bHeld       = Operand2;
                edgeCount   = 0;
                busyErrors  = (Busy !== 1'b1) ? 1 : 0;
                testIndex++;
            end
            if (Finished && !closed) begin
                if (pending) begin
                    FailCount++;
                    $display("an operation was still in progress at the end of the run");
                end
                $display("tests: %0d passed, %0d failed", PassCount, FailCount);
                closed = 1'b1;
            end
        end
    end

endmodule

//--- bench/MCycleBench.sv
`timescale 1ns/1ps

module MCycleBench import mCyclePkg::*; ();

    localparam int DirectedOps   = 21;
    localparam int RandomOps     = 200;
    // an operation with its idle gap stays within 36 cycles.
    localparam int CycleLimit    = (DirectedOps + RandomOps) * 36 + 200;
    // every operation plus the post-reset check.
    localparam int ExpectedTests = DirectedOps + RandomOps + 1;

    logic        CLK;
    logic        Reset;
    logic        Start;
    mCycleOpT    MCycleOp;
    operandT     Operand1;
    operandT     Operand2;
    operandT     Result1;
    operandT     Result2;
    logic        Busy;
    logic        Done;
    logic        finished;
    int          passCount;
    int          failCount;
    logic        timedOut;
    int unsigned lcgState;

    MCycleUnit UUT (
        .CLK      (CLK),
        .Reset    (Reset),
        .Start    (Start),
        .MCycleOp (MCycleOp),
        .Operand1 (Operand1),
        .Operand2 (Operand2),
        .Result1  (Result1),
        .Result2  (Result2),
        .Busy     (Busy),
        .Done     (Done)
    );

    MCycleChecker resultChecker (
        .CLK        (CLK),
        .Reset      (Reset),
        .Start      (Start),
        .MCycleOp   (MCycleOp),
        .Operand1   (Operand1),
        .Operand2   (Operand2),
        .Result1    (Result1),
        .Result2    (Result2),
        .Busy       (Busy),
        .Done       (Done),
        .Finished   (finished),
        .CycleLimit (CycleLimit),
        .PassCount  (passCount),
        .FailCount  (failCount),
        .TimedOut   (timedOut)
    );

    always #50 CLK = ~CLK;

    function automatic int unsigned lcgNext(int unsigned state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Start stays high until the caller drops it.
    task automatic driveOp(mCycleOpT op, operandT a, operandT b);
        Start    = 1'b1;
        MCycleOp = op;
        Operand1 = a;
        Operand2 = b;
    endtask

    task automatic waitForDone();
        do begin
            @(negedge CLK);
        end while (!Done && !timedOut);
    endtask

    task automatic runOp(mCycleOpT op, operandT a, operandT b);
        driveOp(op, a, b);
        @(negedge CLK);
        Start = 1'b0;
        waitForDone();
        @(negedge CLK);
    endtask

    // a second request while computing must be dropped.
    task automatic runWithIgnoredStart(mCycleOpT op, operandT a, operandT b,
                                       mCycleOpT otherOp, operandT c, operandT d);
        driveOp(op, a, b);
        @(negedge CLK);
        Start = 1'b0;
        repeat (5) @(negedge CLK);
        driveOp(otherOp, c, d);
        @(negedge CLK);
        Start = 1'b0;
        waitForDone();
        // long enough for a wrongly accepted request to finish as well.
        repeat (40) @(negedge CLK);
    endtask

    initial begin
        wait (timedOut === 1'b1);
        $display("Verification failed");
        $finish;
    end

    initial begin
        operandT  a;
        operandT  b;
        mCycleOpT op;
        CLK      = 1'b0;
        Reset    = 1'b1;
        Start    = 1'b0;
        MCycleOp = OpMultiply;
        Operand1 = '0;
        Operand2 = '0;
        finished = 1'b0;
        lcgState = 32'd94011;
        repeat (4) @(negedge CLK);
        Reset = 1'b0;
        // a few idle cycles for the post-reset check.
        repeat (3) @(negedge CLK);

        runOp(OpMultiply, 32'h0000_0000, 32'h1234_5678);
        runOp(OpMultiply, 32'hDEAD_BEEF, 32'h0000_0000);
        runOp(OpMultiply, 32'h0000_0001, 32'hCAFE_BABE);
        runOp(OpMultiply, 32'h89AB_CDEF, 32'h0000_0001);
        runOp(OpMultiply, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
        runOp(OpMultiply, 32'h8000_0000, 32'h8000_0000);
        runOp(OpMultiply, 32'h0001_0000, 32'h0001_0000);
        runOp(OpMultiply, 32'h0000_0004, 32'h2000_0000);

        runOp(OpDivide, 32'd100, 32'd10);
        runOp(OpDivide, 32'hFFFF_FFFF, 32'd3);
        runOp(OpDivide, 32'd1000, 32'd7);
        runOp(OpDivide, 32'h1234_5678, 32'h0000_1000);
        runOp(OpDivide, 32'd5, 32'd9);
        runOp(OpDivide, 32'd0, 32'd5);
        runOp(OpDivide, 32'hABCD_1234, 32'd0);
        runOp(OpDivide, 32'd0, 32'd0);

        runWithIgnoredStart(OpMultiply, 32'h0000_FFFF, 32'h0001_0001,
                            OpDivide, 32'h0000_DEAD, 32'd7);
        runWithIgnoredStart(OpDivide, 32'h8765_4321, 32'h0000_0123,
                            OpMultiply, 32'hFFFF_FFFF, 32'd2);

        // Start held high through each Done cycle chains the operations.
        driveOp(OpMultiply, 32'h1234_5678, 32'h9ABC_DEF0);
        waitForDone();
        driveOp(OpDivide, 32'hFFFF_FFFF, 32'd7);
        waitForDone();
        driveOp(OpMultiply, 32'hFFFF_0000, 32'h0000_FFFF);
        @(negedge CLK);
        Start = 1'b0;
        waitForDone();
        @(negedge CLK);

        for (int i = 0; i < RandomOps; i++) begin
            lcgState = lcgNext(lcgState);
            a        = lcgState;
            lcgState = lcgNext(lcgState);
            b        = lcgState;
            lcgState = lcgNext(lcgState);
            op       = lcgState[31] ? OpDivide : OpMultiply;
            // spread divisor sizes so quotients of every length appear.
            if (op == OpDivide) begin
                b = b >> lcgState[30:26];
            end
            runOp(op, a, b);
        end

        finished = 1'b1;
        @(negedge CLK);
        if (failCount == 0 && passCount == ExpectedTests) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
hw/mCyclePkg.sv
hw/MCycleControl.sv
hw/ShiftAddMultiplier.sv
hw/RestoringDivider.sv
hw/ResultSelect.sv
hw/MCycleUnit.sv
bench/MCycleChecker.sv
bench/MCycleBench.sv

//--- run.sh
#!/bin/sh
# Builds the MCycleUnit testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module MCycleBench -f verilog.f -o MCycleSim

output=$(./obj_dir/MCycleSim)
echo "$output"

# the run passes only when the testbench reports success.
echo "$output" | grep -q "^Verification passed$"
